// File: project.f
+incdir+logic
logic/core_pkg.sv
logic/decode_issue.sv
logic/alu_unit.sv
logic/register_file_and_writeback.sv
logic/core_slice.sv
dv/core_slice_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = core_slice_tb
FILELIST = project.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/core_slice_tb.sv
/* Self-checking testbench for the core slice with random OP and OP-IMM traffic.
   A reference register model predicts every writeback; assertions flag the first mismatch. */
`timescale 1ns/10ps
`include "core_macros.svh"

module core_slice_tb;

    localparam int NUM_INSTR = 400;
    localparam int CYCLE_LIMIT = 4 * NUM_INSTR + 200;

    logic                   clk = 1'b0;
    logic                   rst_n = 1'b0;
    logic                   instr_valid = 1'b0;
    logic [31:0]            instr = '0;
    logic [`REG_ADDR_W-1:0] dbg_addr = '0;
    logic                   issue_stall;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;
    logic [`XLEN-1:0]       dbg_data;
    logic                   trace_issued;
    logic                   trace_operand_stall;
    logic                   trace_unit_stall;
    logic                   trace_illegal;
    logic                   trace_retired;

    // Reference state
    logic [`XLEN-1:0]       model_regs [`REG_COUNT];
    logic [`XLEN-1:0]       exp_data [`REG_COUNT];
    int                     accept_cycle [`REG_COUNT];
    logic [`REG_COUNT-1:0]  busy = '0;
    logic [31:0]            lfsr = 32'd66;
    int                     cycle = 0;
    int                     expected_retired = 0;
    int                     retired = 0;
    logic                   seen_accept = 1'b0;
    logic                   cur_legal;
    logic                   cur_reg_form;
    logic                   cur_hazard;

    core_slice core_slice_inst (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting
    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_error(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Galois LFSR stepped once for each random bit
    function automatic logic [31:0] next_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Legal OP and OP-IMM encodings
    function automatic logic is_legal(logic [31:0] w);
        if (w[6:0] == 7'b0110011) begin
            if (w[31:25] == 7'b0000000) begin
                return w[14:12] != 3'b011;
            end
            return w[31:25] == 7'b0100000 && w[14:12] == 3'b000;
        end
        if (w[6:0] == 7'b0010011) begin
            return w[14:12] inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] expected_result(logic [31:0] w, logic [31:0] a,
                                                    logic [31:0] b);
        case (w[14:12])
            3'b000:  return (w[5] && w[30]) ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    assign cur_legal    = is_legal(instr);
    assign cur_reg_form = instr[6:0] == 7'b0110011;
    assign cur_hazard   = instr_valid && cur_legal &&
                          (busy[instr[19:15]] || (cur_reg_form && busy[instr[24:20]]) ||
                           busy[instr[11:7]]);

    //////////////////////////////////////////////////////////////////////
    // Protocol and trace checks
    a_hazard_stall: assert property (@(posedge clk) disable iff (!rst_n)
        cur_hazard |-> issue_stall)
        else report_error("Operand hazard was not stalled");
    a_operand_trace: assert property (@(posedge clk) disable iff (!rst_n)
        cur_hazard |=> trace_operand_stall)
        else report_error("trace_operand_stall missing after a hazard stall");
    a_stall_trace: assert property (@(posedge clk) disable iff (!rst_n)
        (trace_operand_stall || trace_unit_stall) == $past(instr_valid && issue_stall))
        else report_error("Stall trace events do not match the stall of the cycle before");
    a_illegal_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (instr_valid && !cur_legal) |-> !issue_stall)
        else report_error("Illegal word stalled issue");
    a_illegal_trace: assert property (@(posedge clk) disable iff (!rst_n)
        (instr_valid && !cur_legal) |=> trace_illegal)
        else report_error("trace_illegal missing after an illegal word");
    a_illegal_origin: assert property (@(posedge clk) disable iff (!rst_n)
        trace_illegal |-> $past(instr_valid && !cur_legal))
        else report_error("trace_illegal raised without an illegal word");
    a_issued_trace: assert property (@(posedge clk) disable iff (!rst_n)
        (instr_valid && cur_legal && !issue_stall) |=> trace_issued)
        else report_error("trace_issued missing after an acceptance");
    a_issued_origin: assert property (@(posedge clk) disable iff (!rst_n)
        trace_issued |-> $past(instr_valid && cur_legal && !issue_stall))
        else report_error("trace_issued raised without an acceptance");
    a_retired_trace: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |=> trace_retired)
        else report_error("trace_retired missing after a writeback");
    a_idle_after_reset: assert property (@(posedge clk)
        (rst_n && !seen_accept) |-> !(wb_valid || trace_issued || trace_retired ||
                                      trace_illegal || trace_operand_stall ||
                                      trace_unit_stall))
        else report_error("Output active before the first acceptance");
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (dbg_addr == '0) |-> (dbg_data == '0))
        else report_mismatch("dbg_data", dbg_data, 32'h0);

    //////////////////////////////////////////////////////////////////////
    // Writeback against the reference model
    always @(posedge clk) begin
        if (rst_n && wb_valid) begin
            assert (busy[wb_rd])
                else report_error("Writeback to a register with nothing outstanding");
            assert (wb_data == exp_data[wb_rd])
                else report_mismatch("wb_data", wb_data, exp_data[wb_rd]);
            assert (cycle - accept_cycle[wb_rd] >= 2)
                else report_error("Result retired earlier than two edges after acceptance");
            busy[wb_rd] = 1'b0;
            retired++;
        end
    end

    // Timeout
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            report_error("Timeout, the run exceeded its cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    function automatic logic [31:0] make_instr(logic [4:0] prev_rd);
        logic [4:0]  pool [6];
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [3:0]  kind;
        logic [2:0]  sel;
        logic [6:0]  opc;
        logic [2:0]  f3_reg [8];
        logic [2:0]  f3_imm [5];
        pool = '{5'd0, 5'd1, 5'd2, 5'd3, 5'd5, 5'd7};
        f3_reg = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010, 3'b001, 3'b101};
        f3_imm = '{3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
        rd  = pool[next_bits(3) % 6];
        rs1 = pool[next_bits(3) % 6];
        rs2 = pool[next_bits(3) % 6];
        // Force a read of the previous destination now and then
        if (next_bits(2) == 0) begin
            rs1 = prev_rd;
        end
        kind = 4'(next_bits(4));
        sel  = 3'(next_bits(3));
        if (kind == 0) begin
            opc = 7'(next_bits(7));
            if (opc == 7'b0110011 || opc == 7'b0010011) begin
                opc = 7'b1100011;
            end
            return {25'(next_bits(25)), opc};
        end
        if (kind < 8) begin
            // Index 1 is SUB
            return {(sel == 1) ? 7'b0100000 : 7'b0000000, rs2, rs1, f3_reg[sel], rd,
                    7'b0110011};
        end
        return {12'(next_bits(12)), rs1, f3_imm[sel % 5], rd, 7'b0010011};
    endfunction

    task automatic accept_model(logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        if (is_legal(w)) begin
            a = model_regs[w[19:15]];
            b = (w[6:0] == 7'b0110011) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
            res = expected_result(w, a, b);
            if (w[11:7] != 0) begin
                model_regs[w[11:7]] = res;
                exp_data[w[11:7]] = res;
                accept_cycle[w[11:7]] = cycle;
                busy[w[11:7]] = 1'b1;
                expected_retired++;
            end
        end
    endtask

    task automatic send(logic [31:0] w);
        instr_valid <= 1'b1;
        instr <= w;
        do @(posedge clk); while (issue_stall);
        seen_accept = 1'b1;
        accept_model(w);
    endtask

    initial begin
        logic [31:0] w;
        for (int r = 0; r < `REG_COUNT; r++) begin
            model_regs[r] = '0;
            exp_data[r] = '0;
            accept_cycle[r] = 0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            if (next_bits(3) == 0) begin
                instr_valid <= 1'b0;
                @(posedge clk);
            end
            w = make_instr(instr[11:7]);
            send(w);
        end
        instr_valid <= 1'b0;
        while (busy != '0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        // Final register file sweep
        for (int r = 0; r < `REG_COUNT; r++) begin
            dbg_addr <= r[`REG_ADDR_W-1:0];
            @(posedge clk);
            assert (dbg_data == model_regs[r])
                else report_mismatch("dbg_data", dbg_data, model_regs[r]);
        end
        if (retired != expected_retired) begin
            report_error("Retirement count differs from legal instructions with nonzero rd");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// File: logic/core_slice.sv
/* Top level of the integer issue and execute slice.
   Connects decode, the ALU units and writeback, and registers the trace events. */
`timescale 1ns/10ps
`include "core_macros.svh"

module core_slice (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  core_pkg::instr_t       instr,
    input  logic [`REG_ADDR_W-1:0] dbg_addr,
    output logic                   issue_stall,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data,
    output logic [`XLEN-1:0]       dbg_data,
    output logic                   trace_issued,
    output logic                   trace_operand_stall,
    output logic                   trace_unit_stall,
    output logic                   trace_illegal,
    output logic                   trace_retired
);

    // Issue side
    logic [`NUM_ALU_UNITS-1:0] issue;
    logic [`NUM_ALU_UNITS-1:0] unit_ready;
    core_pkg::alu_op_t         alu_op;
    logic [`XLEN-1:0]          operand_a;
    logic [`XLEN-1:0]          operand_b;
    logic [`REG_ADDR_W-1:0]    issue_rd;

    // Register reads
    logic [`REG_ADDR_W-1:0]    rs1_addr;
    logic [`REG_ADDR_W-1:0]    rs2_addr;
    logic [`XLEN-1:0]          rs1_data;
    logic [`XLEN-1:0]          rs2_data;

    // Unit results and writeback
    logic [`NUM_ALU_UNITS-1:0] result_valid;
    logic [`REG_ADDR_W-1:0]    result_rd   [`NUM_ALU_UNITS];
    logic [`XLEN-1:0]          result_data [`NUM_ALU_UNITS];
    logic [`NUM_ALU_UNITS-1:0] wb_ack;
    logic                      clear_valid;
    logic [`REG_ADDR_W-1:0]    clear_rd;

    // Same-cycle trace events
    logic                      ev_issued;
    logic                      ev_operand_stall;
    logic                      ev_unit_stall;
    logic                      ev_illegal;

    //////////////////////////////////////////////////////////////////////
    // Decode and issue
    decode_issue decode_issue_inst (.*);

    //////////////////////////////////////////////////////////////////////
    // Execution units
    for (genvar u = 0; u < `NUM_ALU_UNITS; u++) begin : gen_alu
        alu_unit alu_unit_inst (
            .clk          (clk),
            .rst_n        (rst_n),
            .issue        (issue[u]),
            .alu_op       (alu_op),
            .operand_a    (operand_a),
            .operand_b    (operand_b),
            .issue_rd     (issue_rd),
            .wb_ack       (wb_ack[u]),
            .unit_ready   (unit_ready[u]),
            .result_valid (result_valid[u]),
            .result_rd    (result_rd[u]),
            .result_data  (result_data[u])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Register file and writeback
    register_file_and_writeback register_file_and_writeback_inst (.*);

    //////////////////////////////////////////////////////////////////////
    // Trace events, one cycle behind the cycle they describe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trace_issued        <= 1'b0;
            trace_operand_stall <= 1'b0;
            trace_unit_stall    <= 1'b0;
            trace_illegal       <= 1'b0;
            trace_retired       <= 1'b0;
        end else begin
            trace_issued        <= ev_issued;
            trace_operand_stall <= ev_operand_stall;
            trace_unit_stall    <= ev_unit_stall;
            trace_illegal       <= ev_illegal;
            trace_retired       <= wb_valid;
        end
    end

endmodule

// File: logic/register_file_and_writeback.sv
/* Fixed-priority writeback into the integer register file.
   Lowest-index valid unit wins; operand and debug reads are combinational. */
`timescale 1ns/10ps
`include "core_macros.svh"

module register_file_and_writeback (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`NUM_ALU_UNITS-1:0] result_valid,
    input  logic [`REG_ADDR_W-1:0]    result_rd   [`NUM_ALU_UNITS],
    input  logic [`XLEN-1:0]          result_data [`NUM_ALU_UNITS],
    input  logic [`REG_ADDR_W-1:0]    rs1_addr,
    input  logic [`REG_ADDR_W-1:0]    rs2_addr,
    input  logic [`REG_ADDR_W-1:0]    dbg_addr,
    output logic [`NUM_ALU_UNITS-1:0] wb_ack,
    output logic [`XLEN-1:0]          rs1_data,
    output logic [`XLEN-1:0]          rs2_data,
    output logic [`XLEN-1:0]          dbg_data,
    output logic                      clear_valid,
    output logic [`REG_ADDR_W-1:0]    clear_rd,
    output logic                      wb_valid,
    output logic [`REG_ADDR_W-1:0]    wb_rd,
    output logic [`XLEN-1:0]          wb_data
);

    logic [`XLEN-1:0]       regs [`REG_COUNT];
    logic                   grant_any;
    logic [`REG_ADDR_W-1:0] grant_rd;
    logic [`XLEN-1:0]       grant_data;

    //////////////////////////////////////////////////////////////////////
    // Writeback arbitration
    assign grant_any = |result_valid;

    always_comb begin
        wb_ack     = '0;
        grant_rd   = '0;
        grant_data = '0;
        for (int k = `NUM_ALU_UNITS - 1; k >= 0; k--) begin
            if (result_valid[k]) begin
                wb_ack     = '0;
                wb_ack[k]  = 1'b1;
                grant_rd   = result_rd[k];
                grant_data = result_data[k];
            end
        end
    end

    // Results for x0 drain but do not retire
    assign wb_valid    = grant_any && (grant_rd != '0);
    assign wb_rd       = grant_rd;
    assign wb_data     = grant_data;
    assign clear_valid = wb_valid;
    assign clear_rd    = grant_rd;

    //////////////////////////////////////////////////////////////////////
    // Register storage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // x0 is cleared at reset and never written, so it reads zero
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign dbg_data = regs[dbg_addr];

endmodule

// File: logic/alu_unit.sv
/* Single registered ALU stage with a one-entry result buffer.
   The result is held until writeback acknowledges it, then the unit takes new work. */
`timescale 1ns/10ps
`include "core_macros.svh"

module alu_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue,
    input  core_pkg::alu_op_t      alu_op,
    input  logic [`XLEN-1:0]       operand_a,
    input  logic [`XLEN-1:0]       operand_b,
    input  logic [`REG_ADDR_W-1:0] issue_rd,
    input  logic                   wb_ack,
    output logic                   unit_ready,
    output logic                   result_valid,
    output logic [`REG_ADDR_W-1:0] result_rd,
    output logic [`XLEN-1:0]       result_data
);

    logic [`XLEN-1:0] alu_result;
    logic             less_than;

    //////////////////////////////////////////////////////////////////////
    // Operation select
    assign less_than = $signed(operand_a) < $signed(operand_b);

    always_comb begin
        case (alu_op)
            core_pkg::ALU_ADD: alu_result = operand_a + operand_b;
            core_pkg::ALU_SUB: alu_result = operand_a - operand_b;
            core_pkg::ALU_AND: alu_result = operand_a & operand_b;
            core_pkg::ALU_OR:  alu_result = operand_a | operand_b;
            core_pkg::ALU_XOR: alu_result = operand_a ^ operand_b;
            core_pkg::ALU_SLT: alu_result = {{(`XLEN - 1){1'b0}}, less_than};
            // Shift amount is the low five bits only
            core_pkg::ALU_SLL: alu_result = operand_a << operand_b[4:0];
            core_pkg::ALU_SRL: alu_result = operand_a >> operand_b[4:0];
            default:           alu_result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Result buffer
    // Ready also while the held result drains this cycle
    assign unit_ready = !result_valid || wb_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else if (issue) begin
            result_valid <= 1'b1;
        end else if (wb_ack) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            result_rd   <= issue_rd;
            result_data <= alu_result;
        end
    end

endmodule

// File: logic/decode_issue.sv
/* Decode, hazard scoreboard and issue stage of the core slice.
   Accepts one instruction against issue_stall and issues it one cycle later to a free ALU. */
`timescale 1ns/10ps
`include "core_macros.svh"

module decode_issue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          instr_valid,
    input  core_pkg::instr_t              instr,
    input  logic [`XLEN-1:0]              rs1_data,
    input  logic [`XLEN-1:0]              rs2_data,
    input  logic [`NUM_ALU_UNITS-1:0]     unit_ready,
    input  logic                          clear_valid,
    input  logic [`REG_ADDR_W-1:0]        clear_rd,
    output logic                          issue_stall,
    output logic [`NUM_ALU_UNITS-1:0]     issue,
    output core_pkg::alu_op_t             alu_op,
    output logic [`XLEN-1:0]              operand_a,
    output logic [`XLEN-1:0]              operand_b,
    output logic [`REG_ADDR_W-1:0]        issue_rd,
    output logic [`REG_ADDR_W-1:0]        rs1_addr,
    output logic [`REG_ADDR_W-1:0]        rs2_addr,
    output logic                          ev_issued,
    output logic                          ev_operand_stall,
    output logic                          ev_unit_stall,
    output logic                          ev_illegal
);

    logic                      legal;
    logic                      reg_form;
    core_pkg::alu_op_t         dec_op;
    logic [`XLEN-1:0]          imm_ext;
    logic [`REG_ADDR_W-1:0]    dec_rd;
    logic [`REG_COUNT-1:0]     pending;
    logic                      operand_hazard;
    logic [`NUM_ALU_UNITS-1:0] unit_avail;
    logic [`NUM_ALU_UNITS-1:0] unit_sel;
    logic                      no_unit;
    logic                      accept;

    //////////////////////////////////////////////////////////////////////
    // Decode through both views of the word
    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;
    assign dec_rd   = instr.r.rd;
    assign imm_ext  = {{(`XLEN - 12){instr.i.imm[11]}}, instr.i.imm};

    always_comb begin
        legal    = 1'b0;
        reg_form = 1'b0;
        dec_op   = core_pkg::ALU_ADD;
        case (instr.r.opcode)
            core_pkg::OPCODE_OP: begin
                reg_form = 1'b1;
                if (instr.r.funct7 == core_pkg::FUNCT7_BASE) begin
                    legal = 1'b1;
                    case (instr.r.funct3)
                        core_pkg::FUNCT3_ADD: dec_op = core_pkg::ALU_ADD;
                        core_pkg::FUNCT3_AND: dec_op = core_pkg::ALU_AND;
                        core_pkg::FUNCT3_OR:  dec_op = core_pkg::ALU_OR;
                        core_pkg::FUNCT3_XOR: dec_op = core_pkg::ALU_XOR;
                        core_pkg::FUNCT3_SLT: dec_op = core_pkg::ALU_SLT;
                        core_pkg::FUNCT3_SLL: dec_op = core_pkg::ALU_SLL;
                        core_pkg::FUNCT3_SRL: dec_op = core_pkg::ALU_SRL;
                        default:              legal  = 1'b0;
                    endcase
                end else if (instr.r.funct7 == core_pkg::FUNCT7_ALT &&
                             instr.r.funct3 == core_pkg::FUNCT3_ADD) begin
                    legal  = 1'b1;
                    dec_op = core_pkg::ALU_SUB;
                end
            end
            core_pkg::OPCODE_OP_IMM: begin
                legal = 1'b1;
                case (instr.i.funct3)
                    core_pkg::FUNCT3_ADD: dec_op = core_pkg::ALU_ADD;
                    core_pkg::FUNCT3_AND: dec_op = core_pkg::ALU_AND;
                    core_pkg::FUNCT3_OR:  dec_op = core_pkg::ALU_OR;
                    core_pkg::FUNCT3_XOR: dec_op = core_pkg::ALU_XOR;
                    core_pkg::FUNCT3_SLT: dec_op = core_pkg::ALU_SLT;
                    default:              legal  = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Scoreboard and unit selection
    // rs2 only matters for register forms, the immediate sits in its place
    assign operand_hazard = pending[rs1_addr] || (reg_form && pending[rs2_addr]) ||
                            pending[dec_rd];

    // A unit already targeted by the issue register fills on the next edge
    assign unit_avail = unit_ready & ~issue;
    assign no_unit    = ~|unit_avail;

    always_comb begin
        unit_sel = '0;
        for (int k = `NUM_ALU_UNITS - 1; k >= 0; k--) begin
            if (unit_avail[k]) begin
                unit_sel    = '0;
                unit_sel[k] = 1'b1;
            end
        end
    end

    // Illegal words are dropped without ever stalling
    assign issue_stall = instr_valid && legal && (operand_hazard || no_unit);
    assign accept      = instr_valid && legal && !operand_hazard && !no_unit;

    assign ev_issued        = accept;
    assign ev_operand_stall = instr_valid && legal && operand_hazard;
    assign ev_unit_stall    = instr_valid && legal && no_unit;
    assign ev_illegal       = instr_valid && !legal;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (clear_valid) begin
                pending[clear_rd] <= 1'b0;
            end
            // x0 is never marked
            if (accept && dec_rd != '0) begin
                pending[dec_rd] <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Issue register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue <= '0;
        end else begin
            issue <= unit_sel & {`NUM_ALU_UNITS{accept}};
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alu_op    <= dec_op;
            operand_a <= rs1_data;
            operand_b <= reg_form ? rs2_data : imm_ext;
            issue_rd  <= dec_rd;
        end
    end

endmodule

// File: logic/core_pkg.sv
/* Instruction formats, decode constants and ALU operations of the core slice.
   Referenced by scoped name from the decoder, the ALU units and the top level. */
package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes accepted by the slice
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    // funct3 encodings shared by OP and OP-IMM
    localparam logic [2:0] FUNCT3_ADD = 3'b000;
    localparam logic [2:0] FUNCT3_SLL = 3'b001;
    localparam logic [2:0] FUNCT3_SLT = 3'b010;
    localparam logic [2:0] FUNCT3_XOR = 3'b100;
    localparam logic [2:0] FUNCT3_SRL = 3'b101;
    localparam logic [2:0] FUNCT3_OR  = 3'b110;
    localparam logic [2:0] FUNCT3_AND = 3'b111;

    // funct7 of the register forms, ALT selects SUB
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    //////////////////////////////////////////////////////////////////////
    // Register-register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // Register-immediate format
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // One instruction word seen through either format
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_t;

    //////////////////////////////////////////////////////////////////////
    // Operations executed by an ALU unit
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_t;

endpackage

// File: logic/core_macros.svh
/* Sizes shared by the core slice RTL and its testbench.
   Include this header wherever a data width, unit count or register count is needed. */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Integer data path width
`define XLEN 32

// ALU units behind the issue stage, 1 to 4 supported
`define NUM_ALU_UNITS 2

// Architectural integer registers
`define REG_COUNT 32

// Register address width
`define REG_ADDR_W $clog2(`REG_COUNT)

`endif
